//--- hdl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // Instruction layout.
    localparam int OPERATION_SIZE_BYTES = 1;
    localparam int OPERAND_SIZE_BYTES = 4;
    localparam int INSTRUCTION_SIZE_BYTES = OPERATION_SIZE_BYTES + 2 * OPERAND_SIZE_BYTES;
    localparam int OPERAND_WIDTH = 32;
    localparam int BYTE_IDX_WIDTH = $clog2(INSTRUCTION_SIZE_BYTES);

    localparam int PROGRAM_RAM_BYTES = 1024;
    localparam int RAM_ADDR_WIDTH = $clog2(PROGRAM_RAM_BYTES);

    // Interrupts.
    localparam int NUM_INTERRUPTS = 4;
    localparam int IRQ_IDX_WIDTH = $clog2(NUM_INTERRUPTS);
    localparam logic [7:0] INTERRUPT_TYPE_KEY = 8'd1;
    localparam int SCANCODE_FIFO_DEPTH = 5;
    localparam int INTERRUPT_FIFO_DEPTH = 10;

    // APB register map.
    localparam logic [15:0] CSR_CTRL_ADDR = 16'h0000;
    localparam logic [15:0] CSR_CODE_START_ADDR = 16'h0004;
    localparam logic [15:0] CSR_IRET_ADDR = 16'h0008;
    localparam logic [15:0] CSR_STATUS_ADDR = 16'h000C;
    localparam logic [15:0] CSR_IRQ_VALUE_ADDR = 16'h0010;
    localparam logic [15:0] CSR_VECTOR_BASE_ADDR = 16'h0020;
    localparam logic [15:0] CSR_RAM_BASE_ADDR = 16'h1000;

    typedef logic [OPERAND_WIDTH-1:0] operand_t;
    typedef logic [7:0] operation_t;

    typedef struct packed {
        operand_t   ip;
        operation_t operation;
        operand_t   operand1;
        operand_t   operand2;
    } instruction_t;

    typedef struct packed {
        logic [7:0] irq_type;
        operand_t   value;
    } irq_entry_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] code;
    } scancode_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [15:0] paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic     run;
        logic     irq_enable;
        operand_t code_start;
    } csr_state_t;

    typedef struct packed {
        logic     valid;
        operand_t target;
    } irq_redirect_t;

endpackage

`default_nettype wire

//--- hdl/sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic             CLOCK_50,
    input  logic             rst_n_i,
    input  logic             wr_i,
    input  logic [WIDTH-1:0] data_i,
    input  logic             rd_i,
    output logic [WIDTH-1:0] data_o,
    output logic             empty_o,
    output logic             full_o
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    assign do_wr = wr_i & ~full_o;
    assign do_rd = rd_i & ~empty_o;
    assign empty_o = (count == '0);
    assign full_o = (count == CNT_W'(DEPTH));
    // Head of the queue is visible without a read.
    assign data_o = mem[rd_ptr];

    always_ff @(posedge CLOCK_50)
    begin
        if (do_wr)
        begin
            mem[wr_ptr] <= data_i;
        end
    end

    always_ff @(posedge CLOCK_50)
    begin
        if (!rst_n_i)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (do_wr)
            begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd)
            begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(do_wr) - CNT_W'(do_rd);
        end
    end

endmodule

`default_nettype wire

//--- hdl/program_ram.sv
`timescale 1ns/1ps
`default_nettype none

module program_ram (
    input  logic                               CLOCK_50,
    input  logic                               wr_en_i,
    input  logic [cpu_pkg::RAM_ADDR_WIDTH-1:0] wr_addr_i,
    input  logic [7:0]                         wr_data_i,
    input  logic [cpu_pkg::RAM_ADDR_WIDTH-1:0] rd_addr_i,
    output logic [7:0]                         rd_data_o
);

    import cpu_pkg::*;

    logic [7:0] mem [PROGRAM_RAM_BYTES];

    // Host port writes, fetch port reads one cycle later.
    always_ff @(posedge CLOCK_50)
    begin
        if (wr_en_i)
        begin
            mem[wr_addr_i] <= wr_data_i;
        end
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

`default_nettype wire

//--- hdl/cpu_csr.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_csr (
    input  logic                                                CLOCK_50,
    input  logic                                                rst_n_i,
    input  cpu_pkg::apb_req_t                                   apb_req_i,
    output cpu_pkg::apb_rsp_t                                   apb_rsp_o,
    output cpu_pkg::csr_state_t                                 csr_o,
    output logic                                                ram_wr_en_o,
    output logic [cpu_pkg::RAM_ADDR_WIDTH-1:0]                  ram_wr_addr_o,
    output logic [7:0]                                          ram_wr_data_o,
    output logic                                                iret_o,
    output cpu_pkg::operand_t [cpu_pkg::NUM_INTERRUPTS-1:0]     vector_o,
    input  logic                                                irq_running_i,
    input  cpu_pkg::operand_t                                   irq_value_i
);

    import cpu_pkg::*;

    logic        setup;
    logic        wr_ok;
    logic        in_ram;
    logic        in_vec;
    logic        bad;
    logic [31:0] rd_value;
    logic [31:0] prdata_q;
    logic        pslverr_q;

    assign setup = apb_req_i.psel & ~apb_req_i.penable;
    assign wr_ok = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite & ~bad;
    assign in_ram = (apb_req_i.paddr[15:12] == CSR_RAM_BASE_ADDR[15:12]);
    assign in_vec = (apb_req_i.paddr[15:4] == CSR_VECTOR_BASE_ADDR[15:4]);

    // Address decode, shared by the read mux and the write enables.
    always_comb
    begin
        rd_value = '0;
        bad = 1'b0;
        if (apb_req_i.paddr[1:0] != 2'b00)
            bad = 1'b1;
        else if (in_vec)
            rd_value = vector_o[apb_req_i.paddr[IRQ_IDX_WIDTH+1:2]];
        else if (!in_ram)
        begin
            case (apb_req_i.paddr)
                CSR_CTRL_ADDR:       rd_value = {30'b0, csr_o.irq_enable, csr_o.run};
                CSR_CODE_START_ADDR: rd_value = csr_o.code_start;
                CSR_IRET_ADDR:       rd_value = '0;
                CSR_STATUS_ADDR:
                begin
                    rd_value = {31'b0, irq_running_i};
                    bad = apb_req_i.pwrite;
                end
                CSR_IRQ_VALUE_ADDR:
                begin
                    rd_value = irq_value_i;
                    bad = apb_req_i.pwrite;
                end
                default:             bad = 1'b1;
            endcase
        end
    end

    assign ram_wr_en_o = wr_ok & in_ram;
    assign ram_wr_addr_o = apb_req_i.paddr[RAM_ADDR_WIDTH+1:2];
    assign ram_wr_data_o = apb_req_i.pwdata[7:0];
    assign iret_o = wr_ok & (apb_req_i.paddr == CSR_IRET_ADDR);
    assign apb_rsp_o = '{prdata: prdata_q, pready: 1'b1, pslverr: pslverr_q};

    always_ff @(posedge CLOCK_50)
    begin
        if (!rst_n_i)
        begin
            csr_o <= '0;
            vector_o <= '0;
            prdata_q <= '0;
            pslverr_q <= 1'b0;
        end
        else
        begin
            // Response is prepared in the setup phase.
            if (setup)
            begin
                prdata_q <= (bad || apb_req_i.pwrite) ? '0 : rd_value;
                pslverr_q <= bad;
            end
            if (wr_ok && in_vec)
                vector_o[apb_req_i.paddr[IRQ_IDX_WIDTH+1:2]] <= apb_req_i.pwdata;
            if (wr_ok && apb_req_i.paddr == CSR_CTRL_ADDR)
            begin
                csr_o.run <= apb_req_i.pwdata[0];
                csr_o.irq_enable <= apb_req_i.pwdata[1];
            end
            if (wr_ok && apb_req_i.paddr == CSR_CODE_START_ADDR)
                csr_o.code_start <= apb_req_i.pwdata;
        end
    end

endmodule

`default_nettype wire

//--- hdl/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  logic                               CLOCK_50,
    input  logic                               rst_n_i,
    input  cpu_pkg::csr_state_t                csr_i,
    output logic [cpu_pkg::RAM_ADDR_WIDTH-1:0] rd_addr_o,
    input  logic [7:0]                         rd_data_i,
    output cpu_pkg::instruction_t              instr_o,
    output logic                               instr_valid_o,
    input  logic                               instr_ready_i,
    output logic                               boundary_o,
    input  logic                               done_i,
    input  cpu_pkg::irq_redirect_t             redirect_i
);

    import cpu_pkg::*;

    typedef enum logic [1:0] {IDLE, READ, HOLD, BOUNDARY} state_t;

    state_t                    state;
    operand_t                  ip;
    operand_t                  fetch_addr;
    logic [BYTE_IDX_WIDTH-1:0] byte_idx;
    logic                      phase;
    operation_t                operation_q;
    operand_t                  operand1_q;
    operand_t                  operand2_q;

    assign fetch_addr = ip + operand_t'(byte_idx);
    assign rd_addr_o = fetch_addr[RAM_ADDR_WIDTH-1:0];
    assign instr_o = '{ip: ip, operation: operation_q, operand1: operand1_q,
                       operand2: operand2_q};

    always_ff @(posedge CLOCK_50)
    begin
        if (!rst_n_i)
        begin
            state <= IDLE;
            ip <= '0;
            byte_idx <= '0;
            phase <= 1'b0;
            instr_valid_o <= 1'b0;
            boundary_o <= 1'b0;
        end
        else
        begin
            case (state)
                IDLE:
                    if (csr_i.run)
                    begin
                        ip <= csr_i.code_start;
                        byte_idx <= '0;
                        phase <= 1'b0;
                        state <= READ;
                    end
                // Each byte takes an address cycle and a data cycle.
                READ:
                begin
                    phase <= ~phase;
                    if (phase)
                    begin
                        byte_idx <= byte_idx + 1'b1;
                        if (byte_idx == BYTE_IDX_WIDTH'(INSTRUCTION_SIZE_BYTES - 1))
                        begin
                            instr_valid_o <= 1'b1;
                            state <= HOLD;
                        end
                    end
                end
                HOLD:
                    if (instr_ready_i)
                    begin
                        instr_valid_o <= 1'b0;
                        boundary_o <= 1'b1;
                        state <= BOUNDARY;
                    end
                BOUNDARY:
                begin
                    boundary_o <= 1'b0;
                    if (done_i)
                    begin
                        ip <= redirect_i.valid ? redirect_i.target
                                               : ip + operand_t'(INSTRUCTION_SIZE_BYTES);
                        byte_idx <= '0;
                        phase <= 1'b0;
                        state <= csr_i.run ? READ : IDLE;
                    end
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

    // Operands arrive low byte first.
    always_ff @(posedge CLOCK_50)
    begin
        if (state == READ && phase)
        begin
            if (byte_idx < BYTE_IDX_WIDTH'(OPERATION_SIZE_BYTES))
                operation_q <= rd_data_i;
            else if (byte_idx < BYTE_IDX_WIDTH'(OPERATION_SIZE_BYTES + OPERAND_SIZE_BYTES))
                operand1_q <= {rd_data_i, operand1_q[OPERAND_WIDTH-1:8]};
            else
                operand2_q <= {rd_data_i, operand2_q[OPERAND_WIDTH-1:8]};
        end
    end

endmodule

`default_nettype wire

//--- hdl/interrupt_unit.sv
`timescale 1ns/1ps
`default_nettype none

module interrupt_unit (
    input  logic                                            CLOCK_50,
    input  logic                                            rst_n_i,
    input  cpu_pkg::csr_state_t                             csr_i,
    input  cpu_pkg::scancode_t                              scancode_i,
    input  cpu_pkg::operand_t [cpu_pkg::NUM_INTERRUPTS-1:0] vector_i,
    input  logic                                            iret_i,
    input  logic                                            boundary_i,
    output logic                                            done_o,
    output cpu_pkg::irq_redirect_t                          redirect_o,
    output logic                                            irq_running_o,
    output cpu_pkg::operand_t                               irq_value_o
);

    import cpu_pkg::*;

    logic [7:0] sc_code;
    logic       sc_empty;
    logic       sc_full;
    irq_entry_t irq_head;
    irq_entry_t irq_new;
    logic       irq_empty;
    logic       irq_full;
    logic       dispatch;
    logic       move;
    logic       iret_pending;
    operand_t   cur_ip;
    operand_t   shadow_ip;
    operand_t   vec_target;

    // Codes that find the queue full are dropped.
    sync_fifo #(.WIDTH(8), .DEPTH(SCANCODE_FIFO_DEPTH)) scancode_fifo (
        .CLOCK_50(CLOCK_50),
        .rst_n_i (rst_n_i),
        .wr_i    (scancode_i.valid & ~sc_full),
        .data_i  (scancode_i.code),
        .rd_i    (move),
        .data_o  (sc_code),
        .empty_o (sc_empty),
        .full_o  (sc_full)
    );

    sync_fifo #(.WIDTH($bits(irq_entry_t)), .DEPTH(INTERRUPT_FIFO_DEPTH)) irq_fifo (
        .CLOCK_50(CLOCK_50),
        .rst_n_i (rst_n_i),
        .wr_i    (move),
        .data_i  (irq_new),
        .rd_i    (dispatch),
        .data_o  (irq_head),
        .empty_o (irq_empty),
        .full_o  (irq_full)
    );

    // Dispatch reads the old head before the new entry lands behind it.
    assign dispatch = boundary_i & ~irq_running_o & ~irq_empty;
    assign move = boundary_i & csr_i.irq_enable & ~sc_empty & ~irq_full;
    assign irq_new = '{irq_type: INTERRUPT_TYPE_KEY, value: operand_t'(sc_code)};
    assign vec_target = csr_i.code_start + vector_i[irq_head.irq_type[IRQ_IDX_WIDTH-1:0]];

    always_ff @(posedge CLOCK_50)
    begin
        if (!rst_n_i)
        begin
            done_o <= 1'b0;
            redirect_o.valid <= 1'b0;
            irq_running_o <= 1'b0;
            irq_value_o <= '0;
            iret_pending <= 1'b0;
            cur_ip <= '0;
        end
        else
        begin
            done_o <= boundary_i;
            if (iret_i && irq_running_o)
                iret_pending <= 1'b1;
            // Mirror of the fetch IP, so the return point is known here.
            if (!csr_i.run)
                cur_ip <= csr_i.code_start;
            if (boundary_i)
            begin
                if (iret_pending)
                begin
                    redirect_o <= '{valid: 1'b1, target: shadow_ip};
                    irq_running_o <= 1'b0;
                    iret_pending <= 1'b0;
                    cur_ip <= shadow_ip;
                end
                else if (dispatch)
                begin
                    redirect_o <= '{valid: 1'b1, target: vec_target};
                    irq_running_o <= 1'b1;
                    irq_value_o <= irq_head.value;
                    shadow_ip <= cur_ip + operand_t'(INSTRUCTION_SIZE_BYTES);
                    cur_ip <= vec_target;
                end
                else
                begin
                    redirect_o.valid <= 1'b0;
                    cur_ip <= cur_ip + operand_t'(INSTRUCTION_SIZE_BYTES);
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/cpu_front_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_front_top (
    input  logic                  CLOCK_50,
    input  logic                  rst_n_i,
    input  cpu_pkg::apb_req_t     apb_req_i,
    output cpu_pkg::apb_rsp_t     apb_rsp_o,
    input  cpu_pkg::scancode_t    scancode_i,
    output cpu_pkg::instruction_t instr_o,
    output logic                  instr_valid_o,
    input  logic                  instr_ready_i
);

    import cpu_pkg::*;

    csr_state_t                     csr;
    logic                           ram_wr_en;
    logic [RAM_ADDR_WIDTH-1:0]      ram_wr_addr;
    logic [7:0]                     ram_wr_data;
    logic [RAM_ADDR_WIDTH-1:0]      ram_rd_addr;
    logic [7:0]                     ram_rd_data;
    logic                           iret;
    operand_t [NUM_INTERRUPTS-1:0]  vector;
    logic                           irq_running;
    operand_t                       irq_value;
    logic                           boundary;
    logic                           done;
    irq_redirect_t                  redirect;

    cpu_csr cpu_csr_i (
        .CLOCK_50     (CLOCK_50),
        .rst_n_i      (rst_n_i),
        .apb_req_i    (apb_req_i),
        .apb_rsp_o    (apb_rsp_o),
        .csr_o        (csr),
        .ram_wr_en_o  (ram_wr_en),
        .ram_wr_addr_o(ram_wr_addr),
        .ram_wr_data_o(ram_wr_data),
        .iret_o       (iret),
        .vector_o     (vector),
        .irq_running_i(irq_running),
        .irq_value_i  (irq_value)
    );

    program_ram program_ram_i (
        .CLOCK_50 (CLOCK_50),
        .wr_en_i  (ram_wr_en),
        .wr_addr_i(ram_wr_addr),
        .wr_data_i(ram_wr_data),
        .rd_addr_i(ram_rd_addr),
        .rd_data_o(ram_rd_data)
    );

    fetch_unit fetch_unit_i (
        .CLOCK_50     (CLOCK_50),
        .rst_n_i      (rst_n_i),
        .csr_i        (csr),
        .rd_addr_o    (ram_rd_addr),
        .rd_data_i    (ram_rd_data),
        .instr_o      (instr_o),
        .instr_valid_o(instr_valid_o),
        .instr_ready_i(instr_ready_i),
        .boundary_o   (boundary),
        .done_i       (done),
        .redirect_i   (redirect)
    );

    interrupt_unit interrupt_unit_i (
        .CLOCK_50     (CLOCK_50),
        .rst_n_i      (rst_n_i),
        .csr_i        (csr),
        .scancode_i   (scancode_i),
        .vector_i     (vector),
        .iret_i       (iret),
        .boundary_i   (boundary),
        .done_o       (done),
        .redirect_o   (redirect),
        .irq_running_o(irq_running),
        .irq_value_o  (irq_value)
    );

endmodule

`default_nettype wire

//--- include/cpu_front_tb_tasks.svh
`ifndef CPU_FRONT_TB_TASKS_SVH
`define CPU_FRONT_TB_TASKS_SVH

task automatic compare_rsp(input apb_rsp_t got, input apb_rsp_t want, input string what);
    if (got !== want)
    begin
        error_count++;
        $display("FAILED at %0t: %s: got prdata %h pready %b pslverr %b, expected %h %b %b",
                 $time, what, got.prdata, got.pready, got.pslverr,
                 want.prdata, want.pready, want.pslverr);
    end
endtask

task automatic compare_instr(input instruction_t got, input instruction_t want,
                             input string what);
    if (got !== want)
    begin
        error_count++;
        $display("FAILED at %0t: %s: got ip %h op %h a %h b %h, expected ip %h op %h a %h b %h",
                 $time, what, got.ip, got.operation, got.operand1, got.operand2,
                 want.ip, want.operation, want.operand1, want.operand2);
    end
endtask

task automatic compare_operand(input operand_t got, input operand_t want, input string what);
    if (got !== want)
    begin
        error_count++;
        $display("FAILED at %0t: %s: got %h, expected %h", $time, what, got, want);
    end
endtask

task automatic compare_flag(input logic got, input logic want, input string what);
    if (got !== want)
    begin
        error_count++;
        $display("FAILED at %0t: %s: got %b, expected %b", $time, what, got, want);
    end
endtask

// One APB transfer is a setup phase followed by an access phase.
task automatic apb_access(input logic write, input logic [15:0] addr,
                          input logic [31:0] wdata, output apb_rsp_t rsp);
    int cycles;
    cycles = 0;
    @(posedge CLOCK_50);
    #1;
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
    @(posedge CLOCK_50);
    #1;
    apb_req.penable = 1'b1;
    #1;
    while (apb_rsp.pready !== 1'b1 && cycles < APB_TIMEOUT)
    begin
        @(posedge CLOCK_50);
        #2;
        cycles++;
    end
    if (apb_rsp.pready !== 1'b1)
    begin
        timeout_count++;
        $display("Timeout: pready stayed low for address %h", addr);
    end
    rsp = apb_rsp;
    @(posedge CLOCK_50);
    #1;
    apb_req = '0;
endtask

task automatic write_reg(input logic [15:0] addr, input logic [31:0] data, input logic err);
    apb_rsp_t rsp;
    apb_access(1'b1, addr, data, rsp);
    compare_rsp(rsp, '{prdata: 32'h0, pready: 1'b1, pslverr: err}, "APB write response");
endtask

task automatic read_reg(input logic [15:0] addr, input logic [31:0] data, input logic err);
    apb_rsp_t rsp;
    apb_access(1'b0, addr, 32'h0, rsp);
    compare_rsp(rsp, '{prdata: data, pready: 1'b1, pslverr: err}, "APB read response");
endtask

// Fills the whole program RAM with random bytes and keeps a copy in prog.
task automatic load_program();
    int a;
    for (a = 0; a < PROGRAM_RAM_BYTES; a++)
    begin
        prog[a] = 8'($random(seed));
        write_reg(CSR_RAM_BASE_ADDR + 16'(4 * a), {24'h0, prog[a]}, 1'b0);
    end
endtask

// Valid is high for exactly one cycle per code.
task automatic send_scancode(input logic [7:0] code);
    @(posedge CLOCK_50);
    #1;
    scancode = '{valid: 1'b1, code: code};
    @(posedge CLOCK_50);
    #1;
    scancode = '{valid: 1'b0, code: 8'h00};
endtask

task automatic wait_instr_valid();
    int cycles;
    cycles = 0;
    @(posedge CLOCK_50);
    #1;
    while (instr_valid !== 1'b1 && cycles < FETCH_TIMEOUT)
    begin
        @(posedge CLOCK_50);
        #1;
        cycles++;
    end
    if (instr_valid !== 1'b1)
    begin
        timeout_count++;
        $display("Timeout: no instruction was offered within %0d cycles", FETCH_TIMEOUT);
    end
endtask

// Ready goes high once valid is seen, so the transfer is on the next edge.
task automatic accept_instr(output instruction_t got);
    wait_instr_valid();
    got = instr;
    instr_ready = 1'b1;
    @(posedge CLOCK_50);
    #1;
    instr_ready = 1'b0;
endtask

`endif

//--- tests/cpu_front_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_front_tb;

    import cpu_pkg::*;

    localparam int       FETCH_TIMEOUT = 200;
    localparam int       APB_TIMEOUT = 16;
    localparam int       HOLD_CYCLES = 20;
    localparam operand_t CODE_START = 32'h0000_0040;
    localparam operand_t STEP = operand_t'(INSTRUCTION_SIZE_BYTES);

    logic         CLOCK_50;
    logic         rst_n;
    apb_req_t     apb_req;
    apb_rsp_t     apb_rsp;
    scancode_t    scancode;
    instruction_t instr;
    logic         instr_valid;
    logic         instr_ready;

    logic [7:0]   prog [PROGRAM_RAM_BYTES];
    operand_t     vectors [NUM_INTERRUPTS];
    integer       seed;
    int           error_count;
    int           timeout_count;
    operand_t     last_ip;
    operand_t     irq_target;
    operand_t     return_ip;

    cpu_front_top cpu_front_top_i (
        .CLOCK_50     (CLOCK_50),
        .rst_n_i      (rst_n),
        .apb_req_i    (apb_req),
        .apb_rsp_o    (apb_rsp),
        .scancode_i   (scancode),
        .instr_o      (instr),
        .instr_valid_o(instr_valid),
        .instr_ready_i(instr_ready)
    );

    `include "cpu_front_tb_tasks.svh"

    // Opcode followed by two little-endian operands.
    function automatic instruction_t expected_instr(input operand_t ip);
        instruction_t want;
        operand_t     addr;
        int           i;
        want.ip = ip;
        want.operation = prog[ip[RAM_ADDR_WIDTH-1:0]];
        for (i = 0; i < OPERAND_SIZE_BYTES; i++)
        begin
            addr = ip + operand_t'(OPERATION_SIZE_BYTES + i);
            want.operand1[8*i +: 8] = prog[addr[RAM_ADDR_WIDTH-1:0]];
            addr = addr + operand_t'(OPERAND_SIZE_BYTES);
            want.operand2[8*i +: 8] = prog[addr[RAM_ADDR_WIDTH-1:0]];
        end
        return want;
    endfunction

    // Accepts instructions until one sits at target; all others must be sequential.
    task automatic run_until_ip(input operand_t target, input int limit, input string what,
                                output operand_t resume_ip);
        instruction_t got;
        instruction_t want;
        logic         found;
        int           n;
        found = 1'b0;
        resume_ip = '0;
        for (n = 0; n < limit && !found; n++)
        begin
            accept_instr(got);
            if (got.ip === target)
            begin
                found = 1'b1;
                resume_ip = last_ip + STEP;
                want = expected_instr(target);
            end
            else
                want = expected_instr(last_ip + STEP);
            compare_instr(got, want, what);
            last_ip = want.ip;
        end
        if (!found)
        begin
            error_count++;
            $display("The instruction at IP %h was never offered during %s", target, what);
        end
    endtask

    task automatic sequential_instrs(input int count, input string what);
        instruction_t got;
        int           n;
        for (n = 0; n < count; n++)
        begin
            accept_instr(got);
            compare_instr(got, expected_instr(last_ip + STEP), what);
            compare_operand(got.ip - last_ip, STEP, "IP step");
            last_ip = last_ip + STEP;
        end
    endtask

    task automatic register_access();
        int i;
        read_reg(CSR_CTRL_ADDR, 32'h0, 1'b0);
        read_reg(CSR_CODE_START_ADDR, 32'h0, 1'b0);
        read_reg(CSR_STATUS_ADDR, 32'h0, 1'b0);
        read_reg(CSR_IRQ_VALUE_ADDR, 32'h0, 1'b0);
        for (i = 0; i < NUM_INTERRUPTS; i++)
            read_reg(CSR_VECTOR_BASE_ADDR + 16'(4 * i), 32'h0, 1'b0);
        write_reg(CSR_CODE_START_ADDR, CODE_START, 1'b0);
        read_reg(CSR_CODE_START_ADDR, CODE_START, 1'b0);
        for (i = 0; i < NUM_INTERRUPTS; i++)
            write_reg(CSR_VECTOR_BASE_ADDR + 16'(4 * i), vectors[i], 1'b0);
        for (i = 0; i < NUM_INTERRUPTS; i++)
            read_reg(CSR_VECTOR_BASE_ADDR + 16'(4 * i), vectors[i], 1'b0);
        // Read-only and unmapped addresses answer with an error.
        write_reg(CSR_STATUS_ADDR, 32'h1, 1'b1);
        write_reg(CSR_IRQ_VALUE_ADDR, 32'h5, 1'b1);
        read_reg(16'h0014, 32'h0, 1'b1);
        read_reg(CSR_RAM_BASE_ADDR, 32'h0, 1'b0);
    endtask

    task automatic straight_line_fetch();
        instruction_t first;
        instruction_t second;
        load_program();
        write_reg(CSR_CTRL_ADDR, 32'h1, 1'b0);
        accept_instr(first);
        compare_instr(first, expected_instr(CODE_START), "first instruction");
        accept_instr(second);
        compare_instr(second, expected_instr(CODE_START + STEP), "second instruction");
        compare_operand(second.ip - first.ip, STEP, "IP step");
        last_ip = CODE_START + STEP;
    endtask

    task automatic back_pressure_hold();
        instruction_t held;
        instruction_t got;
        int           n;
        wait_instr_valid();
        held = instr;
        for (n = 0; n < HOLD_CYCLES; n++)
        begin
            @(posedge CLOCK_50);
            #1;
            compare_instr(instr, held, "instruction under back-pressure");
            compare_flag(instr_valid, 1'b1, "valid under back-pressure");
        end
        accept_instr(got);
        compare_instr(got, expected_instr(last_ip + STEP), "instruction after back-pressure");
        last_ip = last_ip + STEP;
    endtask

    task automatic keyboard_interrupt();
        irq_target = CODE_START + vectors[INTERRUPT_TYPE_KEY];
        write_reg(CSR_CTRL_ADDR, 32'h3, 1'b0);
        send_scancode(8'h5A);
        run_until_ip(irq_target, 4, "keyboard interrupt dispatch", return_ip);
        read_reg(CSR_STATUS_ADDR, 32'h1, 1'b0);
        read_reg(CSR_IRQ_VALUE_ADDR, 32'h5A, 1'b0);
        // Queued behind the running interrupt.
        send_scancode(8'h3C);
        sequential_instrs(3, "handler while running");
        read_reg(CSR_IRQ_VALUE_ADDR, 32'h5A, 1'b0);
    endtask

    task automatic interrupt_return();
        operand_t unused_ip;
        operand_t second_return;
        write_reg(CSR_IRET_ADDR, 32'h0, 1'b0);
        run_until_ip(return_ip, 3, "return from interrupt", unused_ip);
        run_until_ip(irq_target, 1, "second scancode dispatch", second_return);
        read_reg(CSR_STATUS_ADDR, 32'h1, 1'b0);
        read_reg(CSR_IRQ_VALUE_ADDR, 32'h3C, 1'b0);
        write_reg(CSR_IRET_ADDR, 32'h0, 1'b0);
        run_until_ip(second_return, 3, "second return", unused_ip);
        read_reg(CSR_STATUS_ADDR, 32'h0, 1'b0);
    endtask

    task automatic interrupts_disabled();
        write_reg(CSR_CTRL_ADDR, 32'h1, 1'b0);
        send_scancode(8'h11);
        send_scancode(8'h22);
        sequential_instrs(4, "scancodes with interrupts disabled");
        read_reg(CSR_STATUS_ADDR, 32'h0, 1'b0);
        read_reg(CSR_IRQ_VALUE_ADDR, 32'h3C, 1'b0);
    endtask

    initial
    begin
        CLOCK_50 = 1'b0;
        forever #4 CLOCK_50 = ~CLOCK_50;
    end

    initial
    begin
        int i;
        seed = 32'hdf1d;
        error_count = 0;
        timeout_count = 0;
        last_ip = '0;
        irq_target = '0;
        return_ip = '0;
        rst_n = 1'b0;
        apb_req = '0;
        scancode = '0;
        instr_ready = 1'b0;
        for (i = 0; i < NUM_INTERRUPTS; i++)
            vectors[i] = 32'h100 + operand_t'(i) * 32'h80;
        repeat (8) @(posedge CLOCK_50);
        #1;
        rst_n = 1'b1;

        register_access();
        straight_line_fetch();
        back_pressure_hold();
        keyboard_interrupt();
        interrupt_return();
        interrupts_disabled();

        $display("Run complete with %0d errors and %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+include
hdl/cpu_pkg.sv
hdl/sync_fifo.sv
hdl/program_ram.sv
hdl/cpu_csr.sv
hdl/fetch_unit.sv
hdl/interrupt_unit.sv
hdl/cpu_front_top.sv
tests/cpu_front_tb.sv
